/* bench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int MODEL_VCS = 2 ** noc_params::VC_SIZE;

// Expected flits per channel, each with the route it must leave on.
noc_params::flit_t exp_flit_q  [MODEL_VCS][$];
noc_params::port_t exp_route_q [MODEL_VCS][$];
noc_params::port_t open_route  [MODEL_VCS];     // Route of the last head.

// Dimension-ordered routing, X resolved before Y.
function automatic noc_params::port_t xy_route(input int x_dest, input int y_dest,
                                               input int x_cur, input int y_cur);
    if (x_dest != x_cur)
        return (x_dest > x_cur) ? noc_params::EAST : noc_params::WEST;
    if (y_dest != y_cur)
        return (y_dest > y_cur) ? noc_params::SOUTH : noc_params::NORTH;
    return noc_params::LOCAL;
endfunction

task automatic expect_flit(input noc_params::flit_t f);
    if (f.flit_label == noc_params::HEAD || f.flit_label == noc_params::HEADTAIL)
        open_route[f.vc_id] = xy_route(int'(f.data.head_data.x_dest),
                                       int'(f.data.head_data.y_dest), X_CURRENT, Y_CURRENT);
    exp_flit_q[f.vc_id].push_back(f);
    exp_route_q[f.vc_id].push_back(open_route[f.vc_id]);
endtask

function automatic int pending();
    int n;
    n = 0;
    for (int v = 0; v < MODEL_VCS; v++)
        n += exp_flit_q[v].size();
    return n;
endfunction

`endif

/* bench/tb_input_port.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_input_port;

    localparam int BUFFER_SIZE = 8;
    localparam int VC_NUM      = 2;
    localparam int X_CURRENT   = 2;
    localparam int Y_CURRENT   = 2;
    localparam int SEED        = 38;
    localparam int PAIRS3      = 3;         // Packet pairs in the alternation test.
    localparam int LEN3        = 3;
    localparam int PKTS5       = 40;
    localparam int MAX_LEN5    = 4;
    localparam int TOTAL_FLITS = 4 + PAIRS3 * 2 * LEN3 + BUFFER_SIZE + PKTS5 * MAX_LEN5;
    localparam int MAX_CYCLES  = 20 * TOTAL_FLITS + 200;

    logic                      clk = 1'b0;
    logic                      rst;
    noc_params::flit_t         flit_i;
    logic                      valid_i;
    logic                      ready_i;
    wire [VC_NUM-1:0]          full_o;
    wire noc_params::flit_t    flit_o;
    wire                       valid_o;
    wire noc_params::port_t    route_o;

    int   errors = 0;
    int   checks = 0;
    int   flits_out = 0;
    int   cycles = 0;
    logic random_ready = 1'b0;
    logic in_packet = 1'b0;                         // Output is inside a packet.
    logic [noc_params::VC_SIZE-1:0] packet_vc = '0;
    int   fixed_x [5] = '{2, 2, 2, 4, 0};           // LOCAL, NORTH, SOUTH, EAST, WEST.
    int   fixed_y [5] = '{2, 0, 4, 1, 3};

    `include "tb_model.svh"

    input_port #(
        .BUFFER_SIZE (BUFFER_SIZE),
        .VC_NUM      (VC_NUM),
        .X_CURRENT   (X_CURRENT),
        .Y_CURRENT   (Y_CURRENT)
    ) i_input_port (
        .clk     (clk),
        .rst     (rst),
        .flit_i  (flit_i),
        .valid_i (valid_i),
        .full_o  (full_o),
        .ready_i (ready_i),
        .flit_o  (flit_o),
        .valid_o (valid_o),
        .route_o (route_o)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    function automatic noc_params::flit_t make_flit(input int vc, input int len, input int idx,
                                                    input int x_dest, input int y_dest);
        noc_params::flit_t f;
        logic [31:0]       r;
        r = $urandom();
        f.vc_id = vc[noc_params::VC_SIZE-1:0];
        if (idx == 0)
        begin
            f.flit_label = (len == 1) ? noc_params::HEADTAIL : noc_params::HEAD;
            f.data.head_data.x_dest  = x_dest[noc_params::DEST_ADDR_SIZE_X-1:0];
            f.data.head_data.y_dest  = y_dest[noc_params::DEST_ADDR_SIZE_Y-1:0];
            f.data.head_data.head_pl = r[noc_params::HEAD_PAYLOAD_SIZE-1:0];
        end
        else
        begin
            f.flit_label   = (idx == len - 1) ? noc_params::TAIL : noc_params::BODY;
            f.data.bt_pl   = r[noc_params::FLIT_DATA_SIZE-1:0];
        end
        return f;
    endfunction

    // Called 1 ns after an edge, returns 1 ns after the edge that took the flit.
    task automatic drive_flit(input noc_params::flit_t f);
        while (full_o[f.vc_id])
        begin
            valid_i = 1'b0;             // Upstream holds off a full channel.
            @(posedge clk);
            #1;
        end
        flit_i  = f;
        valid_i = 1'b1;
        expect_flit(f);
        @(posedge clk);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic send_packet(input int vc, input int len, input int x_dest, input int y_dest);
        for (int j = 0; j < len; j++)
            drive_flit(make_flit(vc, len, j, x_dest, y_dest));
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // Waits for every expected flit, then a few cycles to catch duplicates.
    task automatic wait_drain();
        while (pending() != 0)
            idle(1);
        idle(4);
    endtask

    task automatic end_test(input string name, input int err_start, input int out_start);
        if (errors == err_start)
            $display("test %s: passed, %0d flits out", name, flits_out - out_start);
        else
            $display("test %s: failed with %0d errors", name, errors - err_start);
    endtask

    // ------------------------------------------------------------------
    // Output comparison, sampled away from the rising edge.
    // ------------------------------------------------------------------
    always @(negedge clk)
    begin : compare_output
        int   vc;
        logic head;
        if (!rst && valid_o)
        begin
            vc   = int'(flit_o.vc_id);
            head = (flit_o.flit_label == noc_params::HEAD) ||
                   (flit_o.flit_label == noc_params::HEADTAIL);
            flits_out++;
            if (head)
                check_value("in_packet", 32'(in_packet), 0);
            else
            begin
                check_value("in_packet", 32'(in_packet), 1);
                check_value("flit_o.vc_id", 32'(flit_o.vc_id), 32'(packet_vc));
            end
            in_packet = (flit_o.flit_label == noc_params::HEAD) ||
                        (flit_o.flit_label == noc_params::BODY);
            packet_vc = flit_o.vc_id;
            if (exp_flit_q[vc].size() == 0)
            begin
                errors++;
                $display("flit 0x%0h left on channel %0d but none was expected", flit_o, vc);
            end
            else
            begin
                check_value("flit_o", 32'(flit_o), 32'(exp_flit_q[vc].pop_front()));
                check_value("route_o", 32'(route_o), 32'(exp_route_q[vc].pop_front()));
            end
        end
    end

    always @(posedge clk)
    begin
        #1;
        if (random_ready)
            ready_i = 1'($urandom_range(0, 1));
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles, %0d flits pending",
                     cycles, pending());
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------------
    initial
    begin : stimulus
        int err0;
        int out0;
        void'($urandom(SEED));
        rst     = 1'b1;
        flit_i  = '0;
        valid_i = 1'b0;
        ready_i = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        err0 = errors;
        out0 = flits_out;
        check_value("valid_o", 32'(valid_o), 0);
        check_value("full_o", 32'(full_o), 0);
        idle(1);
        check_value("valid_o", 32'(valid_o), 0);
        end_test("1 reset state", err0, out0);

        err0 = errors;
        out0 = flits_out;
        send_packet(0, 4, 3, 1);
        wait_drain();
        end_test("2 single packet", err0, out0);

        // Flits of two packets interleaved at the input.
        err0 = errors;
        out0 = flits_out;
        for (int p = 0; p < PAIRS3; p++)
            for (int j = 0; j < LEN3; j++)
            begin
                drive_flit(make_flit(0, LEN3, j, p, 2));
                drive_flit(make_flit(1, LEN3, j, 2, 3 + p));
            end
        wait_drain();
        end_test("3 alternating channels", err0, out0);

        err0 = errors;
        out0 = flits_out;
        ready_i = 1'b0;
        send_packet(0, BUFFER_SIZE, 1, 2);
        check_value("full_o", 32'(full_o), 1);
        idle(3);
        check_value("valid_o", 32'(valid_o), 0);
        check_value("full_o", 32'(full_o), 1);
        ready_i = 1'b1;
        idle(1);
        check_value("full_o", 32'(full_o), 0);
        wait_drain();
        end_test("4 full and back-pressure", err0, out0);

        err0 = errors;
        out0 = flits_out;
        random_ready = 1'b1;
        for (int p = 0; p < PKTS5; p++)
        begin
            if (p < 5)
                send_packet($urandom_range(0, 1), $urandom_range(1, MAX_LEN5),
                            fixed_x[p], fixed_y[p]);
            else
                send_packet($urandom_range(0, 1), $urandom_range(1, MAX_LEN5),
                            $urandom_range(0, 15), $urandom_range(0, 15));
            idle($urandom_range(0, 2));
        end
        wait_drain();
        random_ready = 1'b0;
        ready_i = 1'b1;
        end_test("5 random traffic", err0, out0);

        $display("checks %0d, errors %0d, flits out %0d", checks, errors, flits_out);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+bench
verilog/noc_params.sv
verilog/vc_if.sv
verilog/circular_buffer.sv
verilog/input_buffer.sv
verilog/switch_arbiter.sv
verilog/input_port.sv
bench/tb_input_port.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log.
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_input_port \
    -f files.f -o tb_input_port \
    && ./obj_dir/tb_input_port | tee sim.log \
    && grep -q "^Finished with no errors$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verilog/circular_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module circular_buffer #(
    parameter int BUFFER_SIZE = 8
)(
    input  wire                      clk,
    input  wire                      rst,
    input  wire noc_params::flit_t   data_i,
    input  wire                      read_i,
    input  wire                      write_i,
    output noc_params::flit_t        data_o,
    output logic                     is_full_o,
    output logic                     is_empty_o
);

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(BUFFER_SIZE - 1);

    noc_params::flit_t memory [BUFFER_SIZE];

    logic [PTR_W-1:0] read_ptr;
    logic [PTR_W-1:0] write_ptr;
    logic [PTR_W-1:0] read_ptr_next;
    logic [PTR_W-1:0] write_ptr_next;
    logic [PTR_W-1:0] read_ptr_inc;
    logic [PTR_W-1:0] write_ptr_inc;
    logic             is_full_next;
    logic             is_empty_next;
    logic             write_ok;

    // ------------------------------------------------------------------
    // Pointer wrap and next state.
    // ------------------------------------------------------------------
    assign read_ptr_inc  = (read_ptr == LAST_PTR) ? '0 : read_ptr + 1'b1;
    assign write_ptr_inc = (write_ptr == LAST_PTR) ? '0 : write_ptr + 1'b1;

    // A pop frees a slot for a write in the same cycle.
    assign write_ok = write_i & (~is_full_o | read_i);

    always_comb
    begin
        read_ptr_next  = read_ptr;
        write_ptr_next = write_ptr;
        is_full_next   = is_full_o;
        is_empty_next  = is_empty_o;
        if (read_i & ~write_i & ~is_empty_o)
        begin
            read_ptr_next = read_ptr_inc;
            is_full_next  = 1'b0;
            is_empty_next = (read_ptr_inc == write_ptr);
        end
        else if (~read_i & write_i & ~is_full_o)
        begin
            write_ptr_next = write_ptr_inc;
            is_full_next   = (write_ptr_inc == read_ptr);
            is_empty_next  = 1'b0;
        end
        else if (read_i & write_i & ~is_empty_o)
        begin
            // Occupancy unchanged, flags hold.
            read_ptr_next  = read_ptr_inc;
            write_ptr_next = write_ptr_inc;
        end
    end

    // ------------------------------------------------------------------
    // State registers.
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            read_ptr   <= '0;
            write_ptr  <= '0;
            is_full_o  <= 1'b0;
            is_empty_o <= 1'b1;
        end
        else
        begin
            read_ptr   <= read_ptr_next;
            write_ptr  <= write_ptr_next;
            is_full_o  <= is_full_next;
            is_empty_o <= is_empty_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (write_ok)
            memory[write_ptr] <= data_i;
    end

    // Oldest entry is visible as soon as it is stored.
    assign data_o = memory[read_ptr];

endmodule

`default_nettype wire

/* verilog/input_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module input_buffer #(
    parameter int BUFFER_SIZE = 8,
    parameter int X_CURRENT   = 2,
    parameter int Y_CURRENT   = 2
)(
    input  wire                    clk,
    input  wire                    rst,
    input  wire noc_params::flit_t data_i,
    input  wire                    write_i,
    output logic                   is_full_o,
    vc_if.buffer                   vc
);

    localparam logic [noc_params::DEST_ADDR_SIZE_X-1:0] X_CUR =
        X_CURRENT[noc_params::DEST_ADDR_SIZE_X-1:0];
    localparam logic [noc_params::DEST_ADDR_SIZE_Y-1:0] Y_CUR =
        Y_CURRENT[noc_params::DEST_ADDR_SIZE_Y-1:0];

    noc_params::flit_t front_flit;
    logic              is_empty;
    logic              front_is_head;
    noc_params::port_t head_route;
    noc_params::port_t route_q;         // Route of the packet in flight.

    circular_buffer #(
        .BUFFER_SIZE (BUFFER_SIZE)
    ) i_circular_buffer (
        .clk        (clk),
        .rst        (rst),
        .data_i     (data_i),
        .read_i     (vc.read),
        .write_i    (write_i),
        .data_o     (front_flit),
        .is_full_o  (is_full_o),
        .is_empty_o (is_empty)
    );

    assign front_is_head = ~is_empty &
                           ((front_flit.flit_label == noc_params::HEAD) |
                            (front_flit.flit_label == noc_params::HEADTAIL));

    // ------------------------------------------------------------------
    // XY routing, X resolved first.
    // ------------------------------------------------------------------
    always_comb
    begin
        if (front_flit.data.head_data.x_dest > X_CUR)
            head_route = noc_params::EAST;
        else if (front_flit.data.head_data.x_dest < X_CUR)
            head_route = noc_params::WEST;
        else if (front_flit.data.head_data.y_dest > Y_CUR)
            head_route = noc_params::SOUTH;
        else if (front_flit.data.head_data.y_dest < Y_CUR)
            head_route = noc_params::NORTH;
        else
            head_route = noc_params::LOCAL;
    end

    // Body and tail flits follow the route of their head.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            route_q <= noc_params::LOCAL;
        else if (vc.read & front_is_head)
            route_q <= head_route;
    end

    assign vc.flit    = front_flit;
    assign vc.valid   = ~is_empty;
    assign vc.is_head = front_is_head;
    assign vc.route   = front_is_head ? head_route : route_q;

endmodule

`default_nettype wire

/* verilog/input_port.sv */
`timescale 1ns/1ps
`default_nettype none

module input_port #(
    parameter int BUFFER_SIZE = 8,
    parameter int VC_NUM      = 2,
    parameter int X_CURRENT   = 2,
    parameter int Y_CURRENT   = 2
)(
    input  wire                     clk,
    input  wire                     rst,
    input  wire noc_params::flit_t  flit_i,
    input  wire                     valid_i,
    output wire [VC_NUM-1:0]        full_o,
    input  wire                     ready_i,
    output wire noc_params::flit_t  flit_o,
    output wire                     valid_o,
    output wire noc_params::port_t  route_o
);

    vc_if vc_bus [VC_NUM] ();

    logic [VC_NUM-1:0] write_v;

    // One buffer per channel, selected by the flit's own channel number.
    for (genvar i = 0; i < VC_NUM; i++)
    begin : g_channel
        assign write_v[i] = valid_i && (int'(flit_i.vc_id) == i);

        input_buffer #(
            .BUFFER_SIZE (BUFFER_SIZE),
            .X_CURRENT   (X_CURRENT),
            .Y_CURRENT   (Y_CURRENT)
        ) i_input_buffer (
            .clk       (clk),
            .rst       (rst),
            .data_i    (flit_i),
            .write_i   (write_v[i]),
            .is_full_o (full_o[i]),
            .vc        (vc_bus[i])
        );
    end

    switch_arbiter #(
        .VC_NUM (VC_NUM)
    ) i_switch_arbiter (
        .clk     (clk),
        .rst     (rst),
        .vcs     (vc_bus),
        .ready_i (ready_i),
        .flit_o  (flit_o),
        .valid_o (valid_o),
        .route_o (route_o)
    );

endmodule

`default_nettype wire

/* verilog/noc_params.sv */
`default_nettype none

package noc_params;

    // ------------------------------------------------------------------
    // Address and field widths.
    // ------------------------------------------------------------------
    localparam int DEST_ADDR_SIZE_X = 4;
    localparam int DEST_ADDR_SIZE_Y = 4;
    localparam int VC_SIZE = 1;                         // Two channels.
    localparam int FLIT_DATA_SIZE = 16;
    localparam int HEAD_PAYLOAD_SIZE = FLIT_DATA_SIZE - DEST_ADDR_SIZE_X - DEST_ADDR_SIZE_Y;

    // ------------------------------------------------------------------
    // Flit kinds and output directions.
    // ------------------------------------------------------------------
    // HEADTAIL is a whole packet in one flit.
    typedef enum logic [1:0]
    {
        HEAD,
        BODY,
        TAIL,
        HEADTAIL
    } flit_type_t;

    typedef enum logic [2:0]
    {
        LOCAL,
        NORTH,
        SOUTH,
        EAST,
        WEST
    } port_t;

    // ------------------------------------------------------------------
    // Flit format.
    // ------------------------------------------------------------------
    typedef struct packed
    {
        logic [DEST_ADDR_SIZE_X-1:0]  x_dest;
        logic [DEST_ADDR_SIZE_Y-1:0]  y_dest;
        logic [HEAD_PAYLOAD_SIZE-1:0] head_pl;      // Spare bits.
    } head_data_t;

    // Head flits carry the destination, others plain data.
    typedef union packed
    {
        head_data_t                head_data;
        logic [FLIT_DATA_SIZE-1:0] bt_pl;
    } flit_data_t;

    typedef struct packed
    {
        flit_type_t         flit_label;
        logic [VC_SIZE-1:0] vc_id;
        flit_data_t         data;
    } flit_t;

endpackage

`default_nettype wire

/* verilog/switch_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_arbiter #(
    parameter int VC_NUM = 2
)(
    input  wire                clk,
    input  wire                rst,
    vc_if.arbiter              vcs [VC_NUM],
    input  wire                ready_i,
    output noc_params::flit_t  flit_o,
    output logic               valid_o,
    output noc_params::port_t  route_o
);

    localparam int IDX_W = (VC_NUM > 1) ? $clog2(VC_NUM) : 1;

    noc_params::flit_t flit_v  [VC_NUM];
    noc_params::port_t route_v [VC_NUM];
    logic [VC_NUM-1:0] valid_v;
    logic [VC_NUM-1:0] head_v;

    logic              granted_q;       // Packet in progress.
    logic [IDX_W-1:0]  grant_idx_q;
    logic [IDX_W-1:0]  last_idx_q;      // Last channel that finished a packet.
    logic [IDX_W-1:0]  pick_idx;
    logic              pick_found;
    logic [IDX_W-1:0]  cur_idx;
    logic              pop;
    logic              tail_pop;

    // ------------------------------------------------------------------
    // Gather channel signals.
    // ------------------------------------------------------------------
    for (genvar i = 0; i < VC_NUM; i++)
    begin : g_vc
        assign flit_v[i]   = vcs[i].flit;
        assign route_v[i]  = vcs[i].route;
        assign valid_v[i]  = vcs[i].valid;
        assign head_v[i]   = vcs[i].is_head;
        assign vcs[i].read = pop && (int'(cur_idx) == i);
    end

    // Round robin over heads, starting after the last served channel.
    always_comb
    begin
        int idx;
        pick_found = 1'b0;
        pick_idx   = last_idx_q;
        for (int k = VC_NUM; k >= 1; k--)
        begin
            idx = (int'(last_idx_q) + k) % VC_NUM;
            if (head_v[idx])
            begin
                pick_found = 1'b1;              // Smallest offset wins.
                pick_idx   = IDX_W'(idx);
            end
        end
    end

    assign cur_idx  = granted_q ? grant_idx_q : pick_idx;
    assign pop      = ready_i & (granted_q | pick_found) & valid_v[cur_idx];
    assign tail_pop = pop & ((flit_v[cur_idx].flit_label == noc_params::TAIL) |
                             (flit_v[cur_idx].flit_label == noc_params::HEADTAIL));

    // ------------------------------------------------------------------
    // Grant state and output stage.
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            granted_q   <= 1'b0;
            grant_idx_q <= '0;
            last_idx_q  <= IDX_W'(VC_NUM - 1);  // Channel 0 goes first.
            valid_o     <= 1'b0;
        end
        else
        begin
            valid_o <= pop;
            if (tail_pop)
            begin
                granted_q  <= 1'b0;
                last_idx_q <= cur_idx;
            end
            else if (pop)
            begin
                granted_q   <= 1'b1;
                grant_idx_q <= cur_idx;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            flit_o  <= flit_v[cur_idx];
            route_o <= route_v[cur_idx];
        end
    end

endmodule

`default_nettype wire

/* verilog/vc_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Link between one channel buffer and the switch arbiter.
interface vc_if;

    noc_params::flit_t flit;        // Front of the queue.
    logic              valid;       // Channel not empty.
    noc_params::port_t route;       // Direction of the current packet.
    logic              is_head;     // Front flit opens a packet.
    logic              read;        // Pop strobe.

    modport buffer
    (
        output flit,
        output valid,
        output route,
        output is_head,
        input  read
    );

    modport arbiter
    (
        input  flit,
        input  valid,
        input  route,
        input  is_head,
        output read
    );

endinterface

`default_nettype wire
